//--- design/lsu_bit_counter.sv
`default_nettype none

module lsu_bit_counter (
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_cnt_en,
   output logic [1:0] o_bytecnt,
   output logic       o_cnt_done
);

   logic [lsu_op_pkg::CNT_W-1:0] cnt;           // Current serial bit position

   // ========================================
   // Bit position counter
   // ========================================

   // Free-running while enabled and wraps naturally after the last bit,
   // so every init and readout pass starts again from position zero
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt <= '0;                             // Idle position after reset
      end else if (i_cnt_en) begin
         cnt <= cnt + 1'b1;                     // One step per serial cycle
      end
   end

   // Upper two bits tell which byte lane the current bit belongs to
   assign o_bytecnt  = cnt[lsu_op_pkg::CNT_W-1 -: 2];

   // High during the final bit of a pass
   assign o_cnt_done = (cnt == lsu_op_pkg::CNT_LAST);

endmodule

`default_nettype wire

//--- design/lsu_mem_if.sv
`default_nettype none

module lsu_mem_if #(
   parameter bit WITH_MISALIGN_CHECK = 1'b1
) (
   input  logic                         i_clk,
   input  logic                         i_en,
   input  logic                         i_init,
   input  logic                         i_mem_op,
   input  logic [1:0]                   i_bytecnt,
   input  logic [1:0]                   i_lsb,
   input  lsu_op_pkg::width_t           i_width,
   input  logic                         i_signed,
   input  logic                         i_op_b,
   input  logic [wb_bus_pkg::DAT_W-1:0] i_wb_rdt,
   input  logic                         i_wb_ack,
   output logic                         o_rd,
   output logic                         o_misalign,
   output logic [wb_bus_pkg::DAT_W-1:0] o_wb_dat,
   output logic [wb_bus_pkg::SEL_W-1:0] o_wb_sel
);

   localparam int unsigned WORD_BITS = lsu_op_pkg::WORD_BITS;

   logic [WORD_BITS-1:0] dat;                   // Store data or latched load word
   logic                 signbit;               // Last valid load bit, reused for extension
   logic                 is_word;
   logic                 is_half;
   logic                 byte_valid;            // Current byte lane still inside the word
   logic                 dat_en;
   logic                 dat_cur;               // Load bit at the addressed lane
   logic                 dat_valid;             // Current bit lies inside the access width

   assign is_word = (i_width == lsu_op_pkg::WIDTH_WORD);
   assign is_half = (i_width == lsu_op_pkg::WIDTH_HALF);

   // ========================================
   // Serial shifting of the data register
   // ========================================

   // Shifting stops once the byte position plus the offset leaves the word,
   // so a store operand lands on the lanes picked by its address
   assign byte_valid = ({1'b0, i_bytecnt} + {1'b0, i_lsb}) < 3'd4;
   assign dat_en     = i_en & byte_valid;

   always_ff @(posedge i_clk) begin
      if (i_wb_ack) begin
         dat <= i_wb_rdt;                       // Load word arrives with the ack
      end else if (dat_en) begin
         // Operand enters at the top during init, zeros during readout
         dat <= {i_init & i_op_b, dat[WORD_BITS-1:1]};
      end
   end

   // ========================================
   // Load readout
   // ========================================

   // The addressed lane's bit 0 sits at offset times eight
   assign dat_cur   = dat[{i_lsb, 3'b000}];

   // Bytes use only lane 0, halves lanes 0 and 1, words all four
   assign dat_valid = is_word | (i_bytecnt == 2'b00) | (is_half & ~i_bytecnt[1]);

   always_ff @(posedge i_clk) begin
      if (i_en & dat_valid) begin
         signbit <= dat_cur;                    // Ends as the MSB of the accessed value
      end
   end

   // Past the width the last valid bit repeats when signed, else zero
   assign o_rd = i_mem_op & (dat_valid ? dat_cur : (signbit & i_signed));

   // ========================================
   // Bus data, selects and misalignment
   // ========================================

   assign o_wb_dat    = dat;

   assign o_wb_sel[3] = (i_lsb == 2'd3) | is_word | (is_half & i_lsb[1]);
   assign o_wb_sel[2] = (i_lsb == 2'd2) | is_word;
   assign o_wb_sel[1] = (i_lsb == 2'd1) | is_word | (is_half & ~i_lsb[1]);
   assign o_wb_sel[0] = (i_lsb == 2'd0);

   // Only meaningful from the decide phase on, where the sequencer samples it
   assign o_misalign  = WITH_MISALIGN_CHECK &
                        ((i_lsb[0] & (is_word | is_half)) | (i_lsb[1] & is_word));

endmodule

`default_nettype wire

//--- design/lsu_op_pkg.sv
`default_nettype none

package lsu_op_pkg;

   // ========================================
   // Command port encodings
   // ========================================

   typedef logic [1:0] width_t;                 // Access width carried by i_cmd_width

   localparam width_t WIDTH_BYTE = 2'b00;       // Single byte, any offset
   localparam width_t WIDTH_HALF = 2'b01;       // Halfword, offset 0 or 2
   localparam width_t WIDTH_WORD = 2'b10;       // Full word, offset 0 only

   localparam logic OP_LOAD  = 1'b0;            // Value of i_cmd_we for a load
   localparam logic OP_STORE = 1'b1;            // Value of i_cmd_we for a store

   // ========================================
   // Serial datapath constants
   // ========================================

   localparam int unsigned WORD_BITS = 32;      // Bits moved per serial pass
   localparam int unsigned CNT_W     = 5;       // Enough to count WORD_BITS positions

   // Count value of the final bit in a pass
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WORD_BITS - 1);

endpackage

`default_nettype wire

//--- design/lsu_sequencer.sv
`default_nettype none

module lsu_sequencer #(
   parameter int ADDR_W = 32
) (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_cmd_stb,
   input  logic              i_cmd_we,
   input  logic [ADDR_W-1:0] i_cmd_adr,
   input  logic              i_cnt_done,
   input  logic              i_misalign,
   input  logic              i_wb_ack,
   output logic              o_cmd_ack,
   output logic              o_cnt_en,
   output logic              o_init,
   output logic              o_en,
   output logic              o_ser_load,
   output logic              o_des_clr,
   output logic              o_des_en,
   output logic              o_wb_cyc,
   output logic              o_wb_stb,
   output logic              o_wb_we,
   output logic [ADDR_W-1:0] o_wb_adr
);

   localparam int unsigned OFS_W = wb_bus_pkg::OFS_W;

   typedef enum logic [2:0] {
      PH_IDLE,                                  // Waiting for a command strobe
      PH_INIT,                                  // Operand shifts into the data register
      PH_DECIDE,                                // Misalignment is valid here
      PH_BUS,                                   // Wishbone cycle in progress
      PH_READ,                                  // Load result shifts out
      PH_DONE                                   // Ack cycle towards the host
   } phase_t;

   phase_t            phase;
   phase_t            phase_nxt;
   logic              accept;                   // Command taken this cycle
   logic              we_q;                     // Store flag of the command in flight
   logic [ADDR_W-1:0] adr_q;                    // Word address of the command in flight

   assign accept = (phase == PH_IDLE) & i_cmd_stb;

   // ========================================
   // Phase transitions
   // ========================================

   always_comb begin
      phase_nxt = phase;
      case (phase)
         PH_IDLE:   if (i_cmd_stb) phase_nxt = PH_INIT;
         PH_INIT:   if (i_cnt_done) phase_nxt = PH_DECIDE;   // After the 32nd init bit
         PH_DECIDE: phase_nxt = i_misalign ? PH_DONE : PH_BUS;  // No bus cycle if misaligned
         PH_BUS: begin
            if (i_wb_ack) begin
               phase_nxt = we_q ? PH_DONE : PH_READ;    // Stores finish right away
            end
         end
         PH_READ:   if (i_cnt_done) phase_nxt = PH_DONE;
         PH_DONE:   phase_nxt = PH_IDLE;                // Host drops or renews the strobe
         default:   phase_nxt = PH_IDLE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         phase <= PH_IDLE;
         we_q  <= 1'b0;
      end else begin
         phase <= phase_nxt;
         if (accept) begin
            we_q <= (i_cmd_we == lsu_op_pkg::OP_STORE);
         end
      end
   end

   // The bus only ever sees word addresses
   always_ff @(posedge i_clk) begin
      if (accept) begin
         adr_q <= {i_cmd_adr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
      end
   end

   // ========================================
   // Strobes to the datapath and the bus
   // ========================================

   assign o_ser_load = accept;                  // Capture the store operand
   assign o_des_clr  = accept;                  // Stores and misaligned accesses return zero
   assign o_init     = (phase == PH_INIT);
   assign o_des_en   = (phase == PH_READ);
   assign o_cnt_en   = o_init | o_des_en;       // Counter runs in both serial passes
   assign o_en       = o_init | o_des_en;       // Data register shifts in both passes

   assign o_wb_cyc   = (phase == PH_BUS);
   assign o_wb_stb   = (phase == PH_BUS);       // Classic cycle, strobe follows cyc
   assign o_wb_we    = (phase == PH_BUS) & we_q;
   assign o_wb_adr   = adr_q;

   assign o_cmd_ack  = (phase == PH_DONE);

endmodule

`default_nettype wire

//--- design/lsu_top.sv
`default_nettype none

module lsu_top #(
   parameter int ADDR_W              = 32,
   parameter bit WITH_MISALIGN_CHECK = 1'b1
) (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_cmd_stb,
   input  logic                         i_cmd_we,
   input  lsu_op_pkg::width_t           i_cmd_width,
   input  logic                         i_cmd_signed,
   input  logic [ADDR_W-1:0]            i_cmd_adr,
   input  logic [wb_bus_pkg::DAT_W-1:0] i_cmd_dat,
   input  logic [wb_bus_pkg::DAT_W-1:0] i_wb_rdt,
   input  logic                         i_wb_ack,
   output logic                         o_cmd_ack,
   output logic [wb_bus_pkg::DAT_W-1:0] o_cmd_rdat,
   output logic                         o_cmd_misalign,
   output logic                         o_wb_cyc,
   output logic                         o_wb_stb,
   output logic                         o_wb_we,
   output logic [ADDR_W-1:0]            o_wb_adr,
   output logic [wb_bus_pkg::DAT_W-1:0] o_wb_dat,
   output logic [wb_bus_pkg::SEL_W-1:0] o_wb_sel
);

   logic       cnt_en;                          // Counter advance
   logic       cnt_done;                        // Last bit of a serial pass
   logic [1:0] bytecnt;                         // Byte lane of the current bit
   logic       init;                            // Operand pass
   logic       en;                              // Data register shift enable
   logic       ser_load;
   logic       des_clr;
   logic       des_en;                          // Readout pass, also gates the load bit
   logic       ser_bit;                         // Operand bit towards the data register
   logic       rd_bit;                          // Load result bit towards the deserializer

   // ========================================
   // Control
   // ========================================

   lsu_sequencer #(
      .ADDR_W     (ADDR_W)
   ) lsu_sequencer_inst (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_cmd_stb  (i_cmd_stb),
      .i_cmd_we   (i_cmd_we),
      .i_cmd_adr  (i_cmd_adr),
      .i_cnt_done (cnt_done),
      .i_misalign (o_cmd_misalign),             // Flag also goes out with the ack
      .i_wb_ack   (i_wb_ack),
      .o_cmd_ack  (o_cmd_ack),
      .o_cnt_en   (cnt_en),
      .o_init     (init),
      .o_en       (en),
      .o_ser_load (ser_load),
      .o_des_clr  (des_clr),
      .o_des_en   (des_en),
      .o_wb_cyc   (o_wb_cyc),
      .o_wb_stb   (o_wb_stb),
      .o_wb_we    (o_wb_we),
      .o_wb_adr   (o_wb_adr)
   );

   lsu_bit_counter lsu_bit_counter_inst (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_cnt_en   (cnt_en),
      .o_bytecnt  (bytecnt),
      .o_cnt_done (cnt_done)
   );

   // ========================================
   // Serial datapath
   // ========================================

   operand_serializer operand_serializer_inst (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_load  (ser_load),
      .i_shift (init),                          // Operand is only needed during init
      .i_dat   (i_cmd_dat),
      .o_bit   (ser_bit)
   );

   // Width, sign and offset come straight from the held command
   lsu_mem_if #(
      .WITH_MISALIGN_CHECK (WITH_MISALIGN_CHECK)
   ) lsu_mem_if_inst (
      .i_clk      (i_clk),
      .i_en       (en),
      .i_init     (init),
      .i_mem_op   (des_en),
      .i_bytecnt  (bytecnt),
      .i_lsb      (i_cmd_adr[wb_bus_pkg::OFS_W-1:0]),
      .i_width    (i_cmd_width),
      .i_signed   (i_cmd_signed),
      .i_op_b     (ser_bit),
      .i_wb_rdt   (i_wb_rdt),
      .i_wb_ack   (i_wb_ack),
      .o_rd       (rd_bit),
      .o_misalign (o_cmd_misalign),
      .o_wb_dat   (o_wb_dat),
      .o_wb_sel   (o_wb_sel)
   );

   result_deserializer result_deserializer_inst (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_clr (des_clr),
      .i_en  (des_en),
      .i_bit (rd_bit),
      .o_dat (o_cmd_rdat)
   );

endmodule

`default_nettype wire

//--- design/operand_serializer.sv
`default_nettype none

module operand_serializer (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  logic                             i_load,
   input  logic                             i_shift,
   input  logic [lsu_op_pkg::WORD_BITS-1:0] i_dat,
   output logic                             o_bit
);

   logic [lsu_op_pkg::WORD_BITS-1:0] sreg;      // Remaining operand bits, LSB next

   // ========================================
   // Parallel load, serial shift out
   // ========================================

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         sreg <= '0;
      end else if (i_load) begin
         sreg <= i_dat;                         // Captured when the command is taken
      end else if (i_shift) begin
         sreg <= {1'b0, sreg[lsu_op_pkg::WORD_BITS-1:1]};  // Next bit moves into place
      end
   end

   assign o_bit = sreg[0];                      // Bit 0 of the operand first

endmodule

`default_nettype wire

//--- design/result_deserializer.sv
`default_nettype none

module result_deserializer (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  logic                             i_clr,
   input  logic                             i_en,
   input  logic                             i_bit,
   output logic [lsu_op_pkg::WORD_BITS-1:0] o_dat
);

   logic [lsu_op_pkg::WORD_BITS-1:0] word_q;    // Result under assembly

   // ========================================
   // Serial shift in, parallel result
   // ========================================

   always_ff @(posedge i_clk) begin
      if (i_rst | i_clr) begin
         word_q <= '0;                          // Stores and misaligned accesses read zero
      end else if (i_en) begin
         // New bits enter at the top, so the first one ends at bit 0
         word_q <= {i_bit, word_q[lsu_op_pkg::WORD_BITS-1:1]};
      end
   end

   assign o_dat = word_q;

endmodule

`default_nettype wire

//--- design/wb_bus_pkg.sv
`default_nettype none

package wb_bus_pkg;

   // ========================================
   // Wishbone data bus geometry
   // ========================================

   localparam int unsigned DAT_W = 32;          // Data bus width in bits
   localparam int unsigned SEL_W = DAT_W / 8;   // One select line per byte lane

   // Byte offset bits inside a bus word
   // The master drives these address bits as zero
   localparam int unsigned OFS_W = $clog2(SEL_W);

endpackage

`default_nettype wire

//--- tb.f
design/lsu_op_pkg.sv
design/wb_bus_pkg.sv
design/lsu_bit_counter.sv
design/lsu_sequencer.sv
design/lsu_mem_if.sv
design/operand_serializer.sv
design/result_deserializer.sv
design/lsu_top.sv
testbench/wb_mem_model.sv
testbench/lsu_tb.sv

//--- testbench/lsu_tb.sv
`default_nettype none

module lsu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          ADDR_W       = 8;
   localparam int          MEM_WORDS    = 64;
   localparam int          MAX_WAIT     = 3;
   localparam int          RESET_CYCLES = 16;
   localparam logic [31:0] SEED         = 32'h4ee0b56f;

   localparam lsu_op_pkg::width_t W_BYTE = lsu_op_pkg::WIDTH_BYTE;
   localparam lsu_op_pkg::width_t W_HALF = lsu_op_pkg::WIDTH_HALF;
   localparam lsu_op_pkg::width_t W_WORD = lsu_op_pkg::WIDTH_WORD;
   localparam logic LD = lsu_op_pkg::OP_LOAD;
   localparam logic ST = lsu_op_pkg::OP_STORE;

   typedef struct packed {
      logic               we;
      lsu_op_pkg::width_t width;
      logic               sgn;
      logic [ADDR_W-1:0]  adr;
      logic [31:0]        dat;
      logic               exp_mis;             // Expected misalign flag
      logic [31:0]        exp_rdat;            // Expected result with the ack
   } cmd_t;

   logic                         clk;
   logic                         rst;
   logic                         cmd_stb;
   logic                         cmd_we;
   lsu_op_pkg::width_t           cmd_width;
   logic                         cmd_signed;
   logic [ADDR_W-1:0]            cmd_adr;
   logic [wb_bus_pkg::DAT_W-1:0] cmd_dat;
   logic                         cmd_ack;
   logic [wb_bus_pkg::DAT_W-1:0] cmd_rdat;
   logic                         cmd_misalign;
   logic                         wb_cyc;
   logic                         wb_stb;
   logic                         wb_we;
   logic [ADDR_W-1:0]            wb_adr;
   logic [wb_bus_pkg::DAT_W-1:0] wb_dat;
   logic [wb_bus_pkg::SEL_W-1:0] wb_sel;
   logic [wb_bus_pkg::DAT_W-1:0] wb_rdt;
   logic                         wb_ack;

   logic [31:0] ref_mem [MEM_WORDS];           // Expected memory contents
   cmd_t        cmd_table [$];
   int unsigned cycles      = 0;
   int unsigned cycle_limit = 0;               // Set once the table is known

   lsu_top #(
      .ADDR_W              (ADDR_W),
      .WITH_MISALIGN_CHECK (1'b1)
   ) lsu_top_inst (
      .i_clk          (clk),
      .i_rst          (rst),
      .i_cmd_stb      (cmd_stb),
      .i_cmd_we       (cmd_we),
      .i_cmd_width    (cmd_width),
      .i_cmd_signed   (cmd_signed),
      .i_cmd_adr      (cmd_adr),
      .i_cmd_dat      (cmd_dat),
      .i_wb_rdt       (wb_rdt),
      .i_wb_ack       (wb_ack),
      .o_cmd_ack      (cmd_ack),
      .o_cmd_rdat     (cmd_rdat),
      .o_cmd_misalign (cmd_misalign),
      .o_wb_cyc       (wb_cyc),
      .o_wb_stb       (wb_stb),
      .o_wb_we        (wb_we),
      .o_wb_adr       (wb_adr),
      .o_wb_dat       (wb_dat),
      .o_wb_sel       (wb_sel)
   );

   wb_mem_model #(
      .ADDR_W   (ADDR_W),
      .WORDS    (MEM_WORDS),
      .MAX_WAIT (MAX_WAIT),
      .SEED     (SEED)
   ) wb_mem_model_inst (
      .i_clk (clk),
      .i_rst (rst),
      .i_cyc (wb_cyc),
      .i_stb (wb_stb),
      .i_we  (wb_we),
      .i_adr (wb_adr),
      .i_dat (wb_dat),
      .i_sel (wb_sel),
      .o_rdt (wb_rdt),
      .o_ack (wb_ack)
   );

   // ========================================
   // Reference model
   // ========================================

   function automatic logic [31:0] fill_word(input int unsigned index);
      return (index * 32'h9E3779B1) ^ 32'h5A5A5A5A;  // Same preload as the bus slave
   endfunction

   // Right-align the addressed lane, then extend past the access width
   function automatic logic [31:0] load_value(input logic [31:0] word,
                                              input lsu_op_pkg::width_t width,
                                              input logic sgn, input logic [1:0] lane);
      logic [31:0] shifted;
      shifted = word >> (lane * 8);
      case (width)
         W_BYTE:  return sgn ? {{24{shifted[7]}}, shifted[7:0]} : {24'h0, shifted[7:0]};
         W_HALF:  return sgn ? {{16{shifted[15]}}, shifted[15:0]} : {16'h0, shifted[15:0]};
         default: return word;
      endcase
   endfunction

   function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [31:0] dat,
                                               input lsu_op_pkg::width_t width,
                                               input logic [1:0] lane);
      logic [31:0] mask;
      case (width)
         W_BYTE:  mask = 32'h0000_00FF;
         W_HALF:  mask = 32'h0000_FFFF;
         default: mask = 32'hFFFF_FFFF;
      endcase
      mask = mask << (lane * 8);               // Move the mask onto the addressed lanes
      return (old & ~mask) | ((dat << (lane * 8)) & mask);
   endfunction

   // Byte lanes that an access of this width touches at this offset
   function automatic logic [3:0] byte_selects(input lsu_op_pkg::width_t width,
                                                input logic [1:0] lane);
      case (width)
         W_BYTE:  return 4'b0001 << lane;
         W_HALF:  return 4'b0011 << lane;
         default: return 4'b1111;
      endcase
   endfunction

   // Expected results follow the memory copy in table order
   task automatic add_cmd(input logic we, input lsu_op_pkg::width_t width, input logic sgn,
                          input logic [ADDR_W-1:0] adr, input logic [31:0] dat, input logic mis);
      cmd_t       c;
      logic [5:0] idx;
      idx        = adr[7:2];
      c.we       = we;
      c.width    = width;
      c.sgn      = sgn;
      c.adr      = adr;
      c.dat      = dat;
      c.exp_mis  = mis;
      c.exp_rdat = '0;                         // Stores and misaligned accesses read zero
      if (!mis) begin
         if (we) begin
            ref_mem[idx] = store_merge(ref_mem[idx], dat, width, adr[1:0]);
         end else begin
            c.exp_rdat = load_value(ref_mem[idx], width, sgn, adr[1:0]);
         end
      end
      cmd_table.push_back(c);
   endtask

   task automatic build_table();
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i] = fill_word(i);
      end
      add_cmd(LD, W_WORD, 0, 8'h24, 32'h0, 0);          // Untouched preload word
      add_cmd(ST, W_WORD, 0, 8'h10, 32'hDEADBEEF, 0);
      add_cmd(LD, W_WORD, 0, 8'h10, 32'h0, 0);          // Word round trip
      add_cmd(ST, W_BYTE, 0, 8'h21, 32'h123456A5, 0);   // Upper operand bytes must not land
      add_cmd(ST, W_BYTE, 0, 8'h23, 32'hFFFFFF3C, 0);
      add_cmd(LD, W_WORD, 0, 8'h20, 32'h0, 0);
      add_cmd(ST, W_BYTE, 0, 8'h20, 32'h000000C3, 0);
      add_cmd(ST, W_BYTE, 0, 8'h22, 32'hAAAAAA7E, 0);
      add_cmd(LD, W_WORD, 0, 8'h20, 32'h0, 0);
      add_cmd(ST, W_HALF, 0, 8'h30, 32'hABCD8421, 0);
      add_cmd(LD, W_WORD, 0, 8'h30, 32'h0, 0);
      add_cmd(ST, W_HALF, 0, 8'h32, 32'h5555F00F, 0);
      add_cmd(LD, W_WORD, 0, 8'h30, 32'h0, 0);
      add_cmd(ST, W_WORD, 0, 8'h40, 32'h80FF7F01, 0);   // Lanes with both sign values
      for (int lane = 0; lane < 4; lane++) begin
         add_cmd(LD, W_BYTE, 1, 8'h40 + lane, 32'h0, 0);
         add_cmd(LD, W_BYTE, 0, 8'h40 + lane, 32'h0, 0);
      end
      add_cmd(LD, W_HALF, 1, 8'h40, 32'h0, 0);
      add_cmd(LD, W_HALF, 0, 8'h40, 32'h0, 0);
      add_cmd(LD, W_HALF, 1, 8'h42, 32'h0, 0);
      add_cmd(LD, W_HALF, 0, 8'h42, 32'h0, 0);
      add_cmd(LD, W_HALF, 1, 8'h3E, 32'h0, 0);          // Extension on preload data
      add_cmd(LD, W_BYTE, 1, 8'h0B, 32'h0, 0);
      add_cmd(ST, W_WORD, 0, 8'h50, 32'h11223344, 0);
      add_cmd(ST, W_HALF, 0, 8'h51, 32'hFFFFFFFF, 1);   // Odd half gets no bus cycle
      add_cmd(ST, W_WORD, 0, 8'h52, 32'hFFFFFFFF, 1);
      add_cmd(LD, W_HALF, 1, 8'h53, 32'h0, 1);
      add_cmd(LD, W_WORD, 0, 8'h51, 32'h0, 1);
      add_cmd(LD, W_WORD, 0, 8'h50, 32'h0, 0);          // Still the aligned store value
      add_cmd(LD, W_BYTE, 0, 8'h53, 32'h0, 0);          // Bytes are never misaligned
      add_cmd(ST, W_WORD, 0, 8'hFC, 32'hCAFEF00D, 0);   // Last word of memory
      add_cmd(ST, W_BYTE, 0, 8'hFD, 32'h0000009A, 0);
      add_cmd(LD, W_WORD, 0, 8'hFC, 32'h0, 0);
      add_cmd(LD, W_HALF, 1, 8'hFE, 32'h0, 0);
   endtask

   // ========================================
   // Checks and command driver
   // ========================================

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("Fail at %0d ns: %s, got %08h, expected %08h", $time, what, actual, expected);
         $display("TESTBENCH FAILED");
         $fatal(1, "Value mismatch");
      end
   endtask

   // Wishbone master outputs while cyc is high, expected from the command fields
   task automatic check_bus(input cmd_t c, input logic [3:0] sel_exp,
                            input logic [31:0] lane_mask, input int index);
      check_value(c.exp_mis, 1'b0, $sformatf("cmd %0d bus cycle while misaligned", index));
      check_value(wb_stb, 1'b1, $sformatf("cmd %0d stb with cyc", index));
      check_value(wb_we, c.we, $sformatf("cmd %0d bus write enable", index));
      check_value(wb_adr, {c.adr[ADDR_W-1:2], 2'b00},
                  $sformatf("cmd %0d bus address", index));
      check_value(wb_sel, sel_exp, $sformatf("cmd %0d byte selects", index));
      if (c.we) begin
         check_value(wb_dat & lane_mask, (c.dat << (c.adr[1:0] * 8)) & lane_mask,
                     $sformatf("cmd %0d store data", index));
      end
   endtask

   // Entered and left on a falling edge
   task automatic issue_command(input cmd_t c, input int index);
      int unsigned bus_acks;
      logic [3:0]  sel_exp;                    // Lanes the bus cycle must select
      logic [31:0] lane_mask;                  // The same lanes as a bit mask
      bus_acks   = 0;
      sel_exp    = byte_selects(c.width, c.adr[1:0]);
      for (int l = 0; l < 4; l++) begin
         lane_mask[l*8 +: 8] = {8{sel_exp[l]}};
      end
      cmd_stb    = 1'b1;
      cmd_we     = c.we;
      cmd_width  = c.width;
      cmd_signed = c.sgn;
      cmd_adr    = c.adr;
      cmd_dat    = c.dat;
      do begin
         @(negedge clk);
         if (wb_cyc) begin
            check_bus(c, sel_exp, lane_mask, index);
         end
         if (wb_ack) begin
            bus_acks++;                        // Bus cycles spent on this command
         end
      end while (!cmd_ack);
      check_value(cmd_rdat, c.exp_rdat, $sformatf("cmd %0d result", index));
      check_value(cmd_misalign, c.exp_mis, $sformatf("cmd %0d misalign flag", index));
      check_value(bus_acks, c.exp_mis ? 0 : 1, $sformatf("cmd %0d bus cycles", index));
      cmd_stb    = 1'b0;
      cmd_we     = 1'b0;
      cmd_width  = W_BYTE;
      cmd_signed = 1'b0;
      cmd_adr    = '0;
      cmd_dat    = '0;
      @(negedge clk);
      check_value(cmd_ack, 0, $sformatf("cmd %0d ack after its ack cycle", index));
      check_value(wb_cyc, 0, $sformatf("cmd %0d bus cycle after ack", index));
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                  // 20 ns period
   end

   initial begin
      forever begin
         @(posedge clk);
         cycles++;
         if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, a command was never acknowledged", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "Timeout");
         end
      end
   end

   initial begin
      rst        = 1'b1;
      cmd_stb    = 1'b0;
      cmd_we     = 1'b0;
      cmd_width  = W_BYTE;
      cmd_signed = 1'b0;
      cmd_adr    = '0;
      cmd_dat    = '0;
      build_table();
      cycle_limit = cmd_table.size() * (70 + MAX_WAIT) + RESET_CYCLES;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_value(cmd_ack, 0, "ack after reset");
      check_value(wb_cyc, 0, "cyc after reset");
      check_value(wb_stb, 0, "stb after reset");
      check_value(wb_we, 0, "we after reset");
      for (int n = 0; n < cmd_table.size(); n++) begin
         issue_command(cmd_table[n], n);
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/wb_mem_model.sv
`default_nettype none

module wb_mem_model #(
   parameter int          ADDR_W   = 8,
   parameter int          WORDS    = 64,
   parameter int          MAX_WAIT = 3,
   parameter logic [31:0] SEED     = 32'h4ee0b56f
) (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_cyc,
   input  logic                         i_stb,
   input  logic                         i_we,
   input  logic [ADDR_W-1:0]            i_adr,
   input  logic [wb_bus_pkg::DAT_W-1:0] i_dat,
   input  logic [wb_bus_pkg::SEL_W-1:0] i_sel,
   output logic [wb_bus_pkg::DAT_W-1:0] o_rdt,
   output logic                         o_ack
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int IDX_W = $clog2(WORDS);
   localparam int OFS_W = wb_bus_pkg::OFS_W;

   logic [wb_bus_pkg::DAT_W-1:0] mem [WORDS];  // Word storage, byte lanes written by select
   logic [IDX_W-1:0]             idx;          // Word index of the current access
   logic                         busy;         // Wait count already drawn for this cycle
   int unsigned                  wait_left;    // Wait states still to insert

   // Preload value built from the whole word index
   function automatic logic [31:0] fill_word(input int unsigned index);
      return (index * 32'h9E3779B1) ^ 32'h5A5A5A5A;
   endfunction

   // ========================================
   // Slave process, one step per clock
   // ========================================

   initial begin
      void'($urandom(SEED));                   // Single seeding for all wait draws
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = fill_word(i);
      end
      o_ack     = 1'b0;
      o_rdt     = '0;
      busy      = 1'b0;
      wait_left = 0;
      forever begin
         @(posedge i_clk);
         if (i_rst) begin
            o_ack <= 1'b0;
            busy  = 1'b0;
         end else begin
            o_ack <= 1'b0;                     // Ack is a single cycle pulse
            if (i_cyc & i_stb & ~o_ack) begin
               if (!busy) begin
                  wait_left = $urandom % (MAX_WAIT + 1);
                  busy      = 1'b1;
               end
               if (wait_left == 0) begin
                  idx = i_adr[IDX_W+OFS_W-1:OFS_W];
                  if (i_we) begin
                     for (int l = 0; l < wb_bus_pkg::SEL_W; l++) begin
                        if (i_sel[l]) begin
                           mem[idx][l*8 +: 8] <= i_dat[l*8 +: 8];  // Only selected lanes change
                        end
                     end
                  end
                  o_rdt <= mem[idx];
                  o_ack <= 1'b1;
                  busy  = 1'b0;
               end else begin
                  wait_left--;                 // Stall one more cycle
               end
            end
         end
      end
   end

endmodule

`default_nettype wire
